// File: game_defines.svh
//####################
// game control constants
// stage count, starting lives and switch synchronizer depth
//####################

`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// number of stages in the play table
`define GAME_NUM_STAGES 4

// lives given at every game start
`define GAME_START_LIVES 3

// flop depth of the switch synchronizers
`define GAME_SYNC_STAGES 2

// bits needed to hold 0 .. GAME_START_LIVES
`define GAME_LIVES_W $clog2(`GAME_START_LIVES + 1)

`endif

// File: game_pkg.sv
//####################
// game control types
// stage and FSM state enums, unit and switch bundles
//####################

`include "game_defines.svh"

package game_pkg;

    // stages in play order
    typedef enum logic [$clog2(`GAME_NUM_STAGES)-1:0] {
        STAGE_MONSTERS,  // monsters and gift
        STAGE_ASTEROIDS, // asteroids and gift
        STAGE_MIXED,     // monsters and asteroids
        STAGE_BOSS       // boss only
    } game_stage;

    // top-level game FSM
    typedef enum logic [2:0] {
        CTRL_RESET,
        CTRL_RUN,
        CTRL_PAUSE,
        CTRL_STAGE_WON,
        CTRL_GAME_OVER
    } ctrl_state;

    // one bit per enemy-side unit, used for enables, restarts and the stage table
    typedef struct packed {
        logic monst;
        logic astero;
        logic boss;
        logic gift;
    } unit_ctrl_t;

    // board switches
    typedef struct packed {
        logic start; // game on/off level
        logic pause; // freeze level
        logic skip;  // cheat button, one advance per press
    } switch_t;

endpackage

// File: switch_conditioner.sv
//####################
// switch conditioner
// synchronizes start, pause and skip and makes a skip press pulse
//####################

`timescale 1ns/1ps

`include "game_defines.svh"

module switch_conditioner (
    input  logic              clk,
    input  logic              resetN,
    input  game_pkg::switch_t sw,
    output game_pkg::switch_t sw_stable,
    output logic              skip_pulse
);

    import game_pkg::*;

    switch_t sync_q [`GAME_SYNC_STAGES]; // sync_q[0] samples the pins
    logic    skip_d;                     // stable skip delayed one cycle

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            for (int i = 0; i < `GAME_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= sw;
            for (int i = 1; i < `GAME_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sw_stable = sync_q[`GAME_SYNC_STAGES-1];

    // edge detect on the stable skip so a held button advances once
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            skip_d <= 1'b0;
        end else begin
            skip_d <= sw_stable.skip;
        end
    end

    assign skip_pulse = sw_stable.skip & ~skip_d; // first cycle of a press

endmodule

// File: stage_controller.sv
//####################
// stage controller
// steps through the stage table and decodes the active enemy units
//####################

`timescale 1ns/1ps

`include "game_defines.svh"

module stage_controller (
    input  logic                 clk,
    input  logic                 resetN,
    input  logic                 stage_advance,
    input  logic                 stage_clear,
    output game_pkg::game_stage  stage_num,
    output game_pkg::unit_ctrl_t stage_en,
    output logic                 all_won
);

    import game_pkg::*;

    logic last_stage; // current stage is the final one of the table

    assign last_stage = (stage_num == game_stage'(`GAME_NUM_STAGES - 1));

    // stage counter, holds at the last stage once everything is won
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            stage_num <= STAGE_MONSTERS;
            all_won   <= 1'b0;
        end else if (stage_clear) begin
            stage_num <= STAGE_MONSTERS;
            all_won   <= 1'b0;
        end else if (stage_advance) begin
            if (last_stage) begin
                all_won <= 1'b1; // no wrap, the game is over
            end else begin
                stage_num <= game_stage'(stage_num + 1'b1);
            end
        end
    end

    // stage table
    always_comb begin
        stage_en = '0;
        case (stage_num)
            STAGE_MONSTERS: begin
                stage_en.monst = 1'b1;
                stage_en.gift  = 1'b1;
            end
            STAGE_ASTEROIDS: begin
                stage_en.astero = 1'b1;
                stage_en.gift   = 1'b1;
            end
            STAGE_MIXED: begin
                stage_en.monst  = 1'b1;
                stage_en.astero = 1'b1;
            end
            STAGE_BOSS: begin
                stage_en.boss = 1'b1;
            end
            default: begin
                stage_en = '0;
            end
        endcase
    end

endmodule

// File: game_controller.sv
//####################
// game controller
// game FSM: reset, run, pause, stage won, game over
// combines the FSM state with the stage table into unit enables and restarts
//####################

`timescale 1ns/1ps

module game_controller (
    input  logic                 clk,
    input  logic                 resetN,
    input  game_pkg::switch_t    sw_stable,
    input  logic                 skip_pulse,
    input  logic                 win_stage,
    input  logic                 player_dead,
    output logic                 player_en,
    output logic                 player_rst_n,
    output logic                 lives_restart,
    output game_pkg::unit_ctrl_t unit_en,
    output game_pkg::unit_ctrl_t unit_rst_n,
    output game_pkg::game_stage  stage_num,
    output logic                 game_won,
    output logic                 game_over
);

    import game_pkg::*;

    ctrl_state  state;
    ctrl_state  next_state;
    unit_ctrl_t stage_en;      // enemy pattern of the current stage
    logic       all_won;
    logic       stage_advance;
    logic       stage_clear;
    logic       advance_req;   // win or skip seen this cycle
    logic       units_on;      // enemy enables follow the stage table
    logic       units_out_rst; // enemy restarts follow the stage table

    assign advance_req = win_stage | skip_pulse;

    // advance only when no higher-priority run condition applies
    assign stage_advance = (state == CTRL_RUN) & sw_stable.start & ~sw_stable.pause
                         & ~player_dead & advance_req;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= CTRL_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CTRL_RESET: begin
                if (sw_stable.start) next_state = CTRL_RUN;
            end
            CTRL_RUN: begin
                if (!sw_stable.start)    next_state = CTRL_RESET;
                else if (sw_stable.pause) next_state = CTRL_PAUSE;
                else if (player_dead)     next_state = CTRL_GAME_OVER;
                else if (advance_req)     next_state = CTRL_STAGE_WON;
            end
            CTRL_PAUSE: begin
                if (!sw_stable.start)     next_state = CTRL_RESET;
                else if (!sw_stable.pause) next_state = CTRL_RUN;
            end
            CTRL_STAGE_WON: begin
                // single cycle, all_won already reflects the advance
                if (!sw_stable.start) next_state = CTRL_RESET;
                else if (all_won)     next_state = CTRL_GAME_OVER;
                else                  next_state = CTRL_RUN;
            end
            CTRL_GAME_OVER: begin
                if (!sw_stable.start) next_state = CTRL_RESET;
            end
            default: begin
                next_state = CTRL_RESET;
            end
        endcase
    end

    // state decode
    assign units_on      = (state == CTRL_RUN) | (state == CTRL_STAGE_WON);
    assign units_out_rst = (state == CTRL_RUN) | (state == CTRL_PAUSE);

    assign player_en     = units_on;
    assign player_rst_n  = (state != CTRL_RESET) & (state != CTRL_GAME_OVER);
    assign lives_restart = (state == CTRL_RESET);
    assign stage_clear   = (state == CTRL_RESET);
    assign game_over     = (state == CTRL_GAME_OVER);
    assign game_won      = all_won;

    assign unit_en    = units_on ? stage_en : '0;
    assign unit_rst_n = units_out_rst ? stage_en : '0; // new stage starts from fresh units

    stage_controller u_stage_controller (
        .clk           (clk),
        .resetN        (resetN),
        .stage_advance (stage_advance),
        .stage_clear   (stage_clear),
        .stage_num     (stage_num),
        .stage_en      (stage_en),
        .all_won       (all_won)
    );

endmodule

// File: lives_keeper.sv
//####################
// lives keeper
// saturating lives counter, flags the player dead at zero
//####################

`timescale 1ns/1ps

`include "game_defines.svh"

module lives_keeper (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     player_hit,
    input  logic                     player_en,
    input  logic                     lives_restart,
    output logic [`GAME_LIVES_W-1:0] lives,
    output logic                     player_dead
);

    logic hit_valid; // hit taken while the player is in play
    logic no_lives;

    assign no_lives  = (lives == '0);
    assign hit_valid = player_hit & player_en; // paused or idle hits are dropped

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lives <= `GAME_LIVES_W'(`GAME_START_LIVES);
        end else if (lives_restart) begin
            lives <= `GAME_LIVES_W'(`GAME_START_LIVES);
        end else if (hit_valid && !no_lives) begin
            lives <= lives - 1'b1; // saturates at zero
        end
    end

    // death is a level, held until the next restart reloads the counter
    assign player_dead = no_lives;

endmodule

// File: game_control_top.sv
//####################
// game control top
// switch conditioner, game controller and lives keeper
//####################

`timescale 1ns/1ps

`include "game_defines.svh"

module game_control_top (
    input  logic                     clk,
    input  logic                     resetN,
    input  game_pkg::switch_t        sw,
    input  logic                     win_stage,
    input  logic                     player_hit,
    output game_pkg::unit_ctrl_t     unit_en,
    output game_pkg::unit_ctrl_t     unit_rst_n,
    output logic                     player_en,
    output logic                     player_rst_n,
    output game_pkg::game_stage      stage_num,
    output logic [`GAME_LIVES_W-1:0] lives,
    output logic                     game_won,
    output logic                     game_over
);

    import game_pkg::*;

    switch_t sw_stable;     // synchronized switch levels
    logic    skip_pulse;
    logic    lives_restart;
    logic    player_dead;

    switch_conditioner u_switch_conditioner (
        .clk        (clk),
        .resetN     (resetN),
        .sw         (sw),
        .sw_stable  (sw_stable),
        .skip_pulse (skip_pulse)
    );

    game_controller u_game_controller (
        .clk           (clk),
        .resetN        (resetN),
        .sw_stable     (sw_stable),
        .skip_pulse    (skip_pulse),
        .win_stage     (win_stage),
        .player_dead   (player_dead),
        .player_en     (player_en),
        .player_rst_n  (player_rst_n),
        .lives_restart (lives_restart),
        .unit_en       (unit_en),
        .unit_rst_n    (unit_rst_n),
        .stage_num     (stage_num),
        .game_won      (game_won),
        .game_over     (game_over)
    );

    lives_keeper u_lives_keeper (
        .clk           (clk),
        .resetN        (resetN),
        .player_hit    (player_hit),
        .player_en     (player_en),
        .lives_restart (lives_restart),
        .lives         (lives),
        .player_dead   (player_dead)
    );

endmodule

// File: tb_game_control.sv
//####################
// game control testbench
// drives switches, win and hit pulses into the game control top
// and checks the outputs against a stage-table model on every edge
//####################

`timescale 1ns/1ps

`include "game_defines.svh"

module tb_game_control;

    import game_pkg::*;

    logic                     clk;
    logic                     resetN;
    switch_t                  sw;
    logic                     win_stage;
    logic                     player_hit;
    unit_ctrl_t               unit_en;
    unit_ctrl_t               unit_rst_n;
    logic                     player_en;
    logic                     player_rst_n;
    game_stage                stage_num;
    logic [`GAME_LIVES_W-1:0] lives;
    logic                     game_won;
    logic                     game_over;

    // expected DUT state, updated on the falling edge before the edge it applies to
    game_stage                exp_stage;
    logic [`GAME_LIVES_W-1:0] exp_lives;
    logic                     exp_won;
    logic                     exp_over;
    logic                     exp_active; // player and units in play
    logic                     model_valid;
    int                       seed;

    game_control_top u_dut (
        .clk          (clk),
        .resetN       (resetN),
        .sw           (sw),
        .win_stage    (win_stage),
        .player_hit   (player_hit),
        .unit_en      (unit_en),
        .unit_rst_n   (unit_rst_n),
        .player_en    (player_en),
        .player_rst_n (player_rst_n),
        .stage_num    (stage_num),
        .lives        (lives),
        .game_won     (game_won),
        .game_over    (game_over)
    );

    always #2 clk = ~clk;

    // enemy units of each stage, bits are monst astero boss gift
    function automatic unit_ctrl_t expected_units(input game_stage stage, input logic frozen);
        unit_ctrl_t pattern;
        case (stage)
            STAGE_MONSTERS:  pattern = 4'b1001;
            STAGE_ASTEROIDS: pattern = 4'b0101;
            STAGE_MIXED:     pattern = 4'b1100;
            STAGE_BOSS:      pattern = 4'b0010;
            default:         pattern = 4'b0000;
        endcase
        if (frozen) begin
            pattern = 4'b0000;
        end
        return pattern;
    endfunction

    task automatic stop_on_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // outputs settle right after the rising edge
    always begin
        @(posedge clk);
        #1;
        if (model_valid) begin
            check_value("unit_en", 32'(unit_en), 32'(expected_units(exp_stage, !exp_active)));
            check_value("player_en", 32'(player_en), 32'(exp_active));
            check_value("stage_num", 32'(stage_num), 32'(exp_stage));
            check_value("lives", 32'(lives), 32'(exp_lives));
            check_value("game_won", 32'(game_won), 32'(exp_won));
            check_value("game_over", 32'(game_over), 32'(exp_over));
        end
    end

    task automatic wait_game_over(input int limit);
        int cycles;
        cycles = 0;
        while (game_over !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (game_over !== 1'b1) begin
            $display("timeout: game over was not reached within %0d cycles", limit);
            stop_on_failure();
        end
    endtask

    task automatic wait_player_en(input int limit);
        int cycles;
        cycles = 0;
        while (player_en !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (player_en !== 1'b1) begin
            $display("timeout: the player was not enabled within %0d cycles", limit);
            stop_on_failure();
        end
    endtask

    task automatic idle_random();
        int gap;
        gap = ($random(seed) & 32'h7) + 1;
        repeat (gap) @(negedge clk);
    endtask

    // returns on the falling edge before the outputs respond
    task automatic drive_switches(input logic start_on, input logic pause_on,
                                  input logic skip_on);
        sw.start = start_on;
        sw.pause = pause_on;
        sw.skip  = skip_on;
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic model_advance(output logic advanced);
        advanced = exp_active; // only a running game takes a win
        if (advanced) begin
            if (exp_stage == STAGE_BOSS) begin
                exp_won = 1'b1;
            end else begin
                exp_stage = exp_stage.next();
            end
        end
    endtask

    // the stage-won cycle is over, a finished table ends the game
    task automatic model_after_advance(input logic advanced);
        if (advanced && exp_won) begin
            exp_active = 1'b0;
            exp_over   = 1'b1;
        end
    endtask

    task automatic pulse_win();
        logic advanced;
        win_stage = 1'b1;
        model_advance(advanced);
        @(negedge clk);
        win_stage = 1'b0;
        if (advanced) begin
            check_value("unit_rst_n", 32'(unit_rst_n), 32'd0); // stage-won cycle
        end
        model_after_advance(advanced);
        @(negedge clk);
    endtask

    task automatic pulse_hit();
        logic counted;
        counted    = exp_active && (exp_lives != '0);
        player_hit = 1'b1;
        if (counted) begin
            exp_lives = exp_lives - `GAME_LIVES_W'(1);
        end
        @(negedge clk);
        player_hit = 1'b0;
        if (counted && exp_lives == '0) begin
            exp_active = 1'b0; // dead player ends the game
            exp_over   = 1'b1;
        end
        @(negedge clk);
    endtask

    task automatic press_skip();
        logic advanced;
        drive_switches(1'b1, 1'b0, 1'b1);
        model_advance(advanced);
        @(negedge clk);
        if (advanced) begin
            check_value("unit_rst_n", 32'(unit_rst_n), 32'd0); // stage-won cycle
        end
        model_after_advance(advanced);
        @(negedge clk);
    endtask

    task automatic release_skip();
        drive_switches(1'b1, 1'b0, 1'b0);
        @(negedge clk);
    endtask

    task automatic set_pause(input logic on);
        drive_switches(1'b1, on, 1'b0);
        exp_active = !on;
        @(negedge clk);
    endtask

    task automatic start_game();
        drive_switches(1'b1, 1'b0, 1'b0);
        exp_active = 1'b1;
        @(negedge clk);
        wait_player_en(8);
        check_value("unit_rst_n", 32'(unit_rst_n), 32'(expected_units(exp_stage, 1'b0)));
    endtask

    // reset state shows first, the counters reload one edge later
    task automatic stop_game();
        drive_switches(1'b0, 1'b0, 1'b0);
        exp_active = 1'b0;
        exp_over   = 1'b0;
        @(negedge clk);
        exp_stage = STAGE_MONSTERS;
        exp_lives = `GAME_LIVES_W'(`GAME_START_LIVES);
        exp_won   = 1'b0;
        @(negedge clk);
        check_value("unit_rst_n", 32'(unit_rst_n), 32'd0);
        check_value("player_rst_n", 32'(player_rst_n), 32'd0);
    endtask

    initial begin
        seed        = 32'h4f1f;
        model_valid = 1'b0;
        clk         = 1'b0;
        resetN      = 1'b0;
        sw          = '0;
        win_stage   = 1'b0;
        player_hit  = 1'b0;
        exp_stage   = STAGE_MONSTERS;
        exp_lives   = `GAME_LIVES_W'(`GAME_START_LIVES);
        exp_won     = 1'b0;
        exp_over    = 1'b0;
        exp_active  = 1'b0;

        repeat (16) @(negedge clk);
        model_valid = 1'b1;
        resetN      = 1'b1;
        check_value("unit_rst_n", 32'(unit_rst_n), 32'd0);
        check_value("player_rst_n", 32'(player_rst_n), 32'd0);

        start_game();

        // walk the whole stage table
        for (int i = 0; i < `GAME_NUM_STAGES; i++) begin
            idle_random();
            pulse_win();
        end
        wait_game_over(8);
        check_value("unit_rst_n", 32'(unit_rst_n), 32'd0);
        check_value("player_rst_n", 32'(player_rst_n), 32'd0);

        stop_game();
        start_game();

        // held skip advances once
        press_skip();
        repeat (20) @(negedge clk);
        release_skip();
        press_skip();
        release_skip();

        set_pause(1'b1);
        check_value("unit_rst_n", 32'(unit_rst_n), 32'(expected_units(exp_stage, 1'b0)));
        pulse_win();
        idle_random();
        pulse_hit();
        set_pause(1'b0);
        idle_random();

        stop_game();
        start_game();

        for (int i = 0; i < `GAME_START_LIVES; i++) begin
            idle_random();
            pulse_hit();
        end
        wait_game_over(8);
        check_value("unit_rst_n", 32'(unit_rst_n), 32'd0);
        check_value("player_rst_n", 32'(player_rst_n), 32'd0);

        stop_game();
        start_game();
        set_pause(1'b1);
        stop_game();
        start_game();
        idle_random();

        $display("Regression passed");
        $finish;
    end

endmodule

// File: game_control_top.f
+incdir+.
game_pkg.sv
switch_conditioner.sv
stage_controller.sv
game_controller.sv
lives_keeper.sv
game_control_top.sv
tb_game_control.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing -f game_control_top.f --top-module tb_game_control -Mdir obj_dir -o sim_game
	./obj_dir/sim_game | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
